// ==== rtl/cu_pkg.sv ====
// cu_pkg: shared ISA constants, instruction layouts and control-word types of the control unit
`default_nettype none

package cu_pkg;

	localparam int instr_w   = 32;
	localparam int reg_idx_w = 5;

	// base opcodes of RV32I
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_fence  = 7'b0001111,
		op_system = 7'b1110011 // csr and environment calls
	} opcode_t;

	// register form
	typedef struct packed {
		logic [6:0]           funct7;
		logic [reg_idx_w-1:0] rs2;
		logic [reg_idx_w-1:0] rs1;
		logic [2:0]           funct3;
		logic [reg_idx_w-1:0] rd;
		opcode_t              opcode;
	} instr_r_t;

	// immediate form
	typedef struct packed {
		logic [11:0]          imm12;
		logic [reg_idx_w-1:0] rs1;
		logic [2:0]           funct3;
		logic [reg_idx_w-1:0] rd;
		opcode_t              opcode;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// funct3 values shared by reg and imm arithmetic
	localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101; // srl / sra, split by bit 30
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// operation codes seen by the ALU
	typedef enum logic [3:0] {
		alu_copy_b = 4'd0,
		alu_addr   = 4'd1, // address generation for load/store
		alu_add    = 4'd2,
		alu_xor    = 4'd3,
		alu_or     = 4'd4,
		alu_and    = 4'd5,
		alu_sll    = 4'd6,
		alu_srl    = 4'd7,
		alu_sra    = 4'd8,
		alu_sub    = 4'd9,
		alu_slt    = 4'd10,
		alu_sltu   = 4'd11
	} alu_op_t;

	typedef struct packed {
		logic pc_en;
		logic fd_en;
	} fe_ctrl_t;

	typedef struct packed {
		logic rs1_en;
		logic rs2_en;
		logic imm_en; // immediate generator
		logic de_en;
	} de_ctrl_t;

	typedef struct packed {
		logic sel_a_pc;
		logic sel_b_imm;
		logic em_en;
	} ex_ctrl_t;

	typedef struct packed {
		logic dram_we;
		logic dram_re;
		logic mw_en;
	} mem_ctrl_t;

	typedef struct packed {
		logic sel_c;
		logic sel_d;
		logic rf_we;
	} wb_ctrl_t;

	// full word, fetch part in the msbs
	typedef struct packed {
		fe_ctrl_t  fe;
		de_ctrl_t  de;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_word_t;

	// empty slot, only the pipeline enables of ex and mem stay on
	localparam ctrl_word_t cw_bubble = {2'b00, 4'b0000, 3'b001, 3'b001, 3'b000};

	// unknown opcode, e.g. while the icache is still empty
	localparam ctrl_word_t cw_fetch_only = {2'b10, 4'b0000, 3'b000, 3'b000, 3'b000};

endpackage

`default_nettype wire

// ==== rtl/cw_rom.sv ====
// cw_rom: combinational table from opcode to the full control word
`timescale 1ns/10ps
`default_nettype none

module cw_rom (
	input  cu_pkg::opcode_t    opcode,
	output cu_pkg::ctrl_word_t cw
);
	import cu_pkg::*;

	// grouped as fe, de, ex, mem, wb
	always_comb begin
		case (opcode)
			op_auipc:  cw = {2'b11, 4'b0011, 3'b011, 3'b001, 3'b101};
			op_lui:    cw = {2'b11, 4'b0011, 3'b111, 3'b001, 3'b101};
			op_branch: cw = {2'b11, 4'b1111, 3'b111, 3'b001, 3'b100}; // no rf write
			op_jal:    cw = {2'b11, 4'b0011, 3'b101, 3'b001, 3'b111};
			op_jalr:   cw = {2'b11, 4'b1011, 3'b011, 3'b001, 3'b111};
			op_load:   cw = {2'b11, 4'b1011, 3'b111, 3'b011, 3'b001};
			op_store:  cw = {2'b11, 4'b1111, 3'b111, 3'b101, 3'b100};
			op_imm:    cw = {2'b11, 4'b1011, 3'b111, 3'b001, 3'b101};
			op_reg:    cw = {2'b11, 4'b1101, 3'b101, 3'b001, 3'b101};
			// fence and system share the register-form word
			op_fence:  cw = {2'b11, 4'b1101, 3'b101, 3'b001, 3'b101};
			op_system: cw = {2'b11, 4'b1101, 3'b101, 3'b001, 3'b101};
			default:   cw = cw_fetch_only; // keep the pc moving
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/hazard_ctrl.sv ====
// hazard_ctrl: read-after-write detection against the instruction in decode, raises a one-cycle stall
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl (
	input  logic                         clk,
	input  logic                         nrst,
	input  cu_pkg::instr_u               instr_in,
	input  logic [cu_pkg::reg_idx_w-1:0] de_rd,
	input  logic                         de_is_load,
	output logic                         stall
);
	import cu_pkg::*;

	opcode_t              opcode;
	logic [reg_idx_w-1:0] rs1;
	logic [reg_idx_w-1:0] rs2;
	logic                 src_match;
	logic                 stall_q;

	assign opcode = instr_in.r.opcode;

	// rs1 sits at the same place in both layouts
	always_comb begin
		case (opcode)
			op_lui, op_auipc, op_jal: rs1 = '0;
			default:                  rs1 = instr_in.i.rs1;
		endcase
	end

	// rs2 only exists in register form
	always_comb begin
		case (opcode)
			op_reg, op_branch, op_store: rs2 = instr_in.r.rs2;
			default:                     rs2 = '0;
		endcase
	end

	assign src_match = (de_rd != '0) && ((de_rd == rs1) || (de_rd == rs2));

	// load feeds anything, or anything feeds a branch
	always_comb begin
		stall = 1'b0;
		if (src_match && !stall_q) begin
			if (de_is_load || (opcode == op_branch))
				stall = 1'b1;
		end
	end

	// the re-presented instruction must not stall twice
	always_ff @(posedge clk) begin
		if (!nrst)
			stall_q <= 1'b0;
		else
			stall_q <= stall;
	end

endmodule

`default_nettype wire

// ==== rtl/alu_decoder.sv ====
// alu_decoder: decodes the fetched instruction into the ALU operation code, one cycle later
`timescale 1ns/10ps
`default_nettype none

module alu_decoder (
	input  logic             clk,
	input  logic             nrst,
	input  cu_pkg::instr_u   instr_in,
	input  logic             stall,
	output cu_pkg::alu_op_t  alu_op
);
	import cu_pkg::*;

	alu_op_t op_next;
	logic    alt_r; // funct7 bit 5, sub / sra
	logic    alt_i; // imm bit 10, srai
	logic    mext;  // funct7 bit 0

	assign alt_r = instr_in.r.funct7[5];
	assign alt_i = instr_in.i.imm12[10];
	assign mext  = instr_in.r.funct7[0];

	always_comb begin
		op_next = alu_copy_b;
		case (instr_in.r.opcode)
			op_lui:             op_next = alu_copy_b;
			op_load, op_store:  op_next = alu_addr;
			op_auipc:           op_next = alu_add;
			op_reg: begin
				if (!mext) begin
					case (instr_in.r.funct3)
						f3_add:  op_next = alt_r ? alu_sub : alu_add;
						f3_sll:  op_next = alu_sll;
						f3_slt:  op_next = alu_slt;
						f3_sltu: op_next = alu_sltu;
						f3_xor:  op_next = alu_xor;
						f3_sr:   op_next = alt_r ? alu_sra : alu_srl;
						f3_or:   op_next = alu_or;
						f3_and:  op_next = alu_and;
						default: op_next = alu_copy_b;
					endcase
				end
			end
			op_imm: begin
				case (instr_in.i.funct3)
					f3_add:  op_next = alu_add; // no subi
					f3_sll:  op_next = alu_sll;
					f3_slt:  op_next = alu_slt;
					f3_sltu: op_next = alu_sltu;
					f3_xor:  op_next = alu_xor;
					f3_sr:   op_next = alt_i ? alu_sra : alu_srl;
					f3_or:   op_next = alu_or;
					f3_and:  op_next = alu_and;
					default: op_next = alu_copy_b;
				endcase
			end
			default:            op_next = alu_copy_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			alu_op <= alu_copy_b;
		else if (stall)
			alu_op <= alu_copy_b; // bubble enters decode
		else
			alu_op <= op_next;
	end

endmodule

`default_nettype wire

// ==== rtl/cw_pipeline.sv ====
// cw_pipeline: carries the control word through decode, execute, memory and writeback
`timescale 1ns/10ps
`default_nettype none

module cw_pipeline (
	input  logic                         clk,
	input  logic                         nrst,
	input  cu_pkg::ctrl_word_t           rom_cw,
	input  logic [cu_pkg::reg_idx_w-1:0] instr_rd,
	input  logic                         stall,
	output cu_pkg::ctrl_word_t           cw_out,
	output logic [cu_pkg::reg_idx_w-1:0] de_rd,
	output logic                         de_is_load
);
	import cu_pkg::*;

	// what is left of the word after each stage
	typedef struct packed {
		de_ctrl_t  de;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} st1_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} st2_t;

	typedef struct packed {
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} st3_t;

	st1_t       st1;
	st2_t       st2;
	st3_t       st3;
	wb_ctrl_t   st4;
	ctrl_word_t next_cw;

	assign next_cw = stall ? cw_bubble : rom_cw;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			st1 <= '0;
			st2 <= '0;
			st3 <= '0;
			st4 <= '0;
		end else begin
			st1 <= {next_cw.de, next_cw.ex, next_cw.mem, next_cw.wb};
			st2 <= {st1.ex, st1.mem, st1.wb}; // later stages never hold
			st3 <= {st2.mem, st2.wb};
			st4 <= st3.wb;
		end
	end

	// producer info for hazard detection
	// branch, store and unknown opcodes have rf_we low, the bubble too
	always_ff @(posedge clk) begin
		if (!nrst) begin
			de_rd      <= '0;
			de_is_load <= 1'b0;
		end else begin
			de_rd      <= next_cw.wb.rf_we ? instr_rd : '0;
			de_is_load <= next_cw.mem.dram_re;
		end
	end

	always_comb begin
		cw_out.fe  = (stall || !nrst) ? '0 : rom_cw.fe; // freeze fetch
		cw_out.de  = st1.de;
		cw_out.ex  = st2.ex;
		cw_out.mem = st3.mem;
		cw_out.wb  = st4;
	end

endmodule

`default_nettype wire

// ==== rtl/cu_top.sv ====
// cu_top: control unit of the five-stage RV32I pipeline, decode, hazard stall and ALU code
`timescale 1ns/10ps
`default_nettype none

module cu_top (
	input  logic               clk,
	input  logic               nrst,
	input  cu_pkg::instr_u     instr_in,
	output cu_pkg::ctrl_word_t cw_out,
	output cu_pkg::alu_op_t    alu_op
);
	import cu_pkg::*;

	ctrl_word_t           rom_cw;
	logic                 stall;
	logic [reg_idx_w-1:0] de_rd;
	logic                 de_is_load;

	cw_rom rom_i (
		.opcode (instr_in.r.opcode),
		.cw     (rom_cw)
	);

	hazard_ctrl hazard_i (
		.clk        (clk),
		.nrst       (nrst),
		.instr_in   (instr_in),
		.de_rd      (de_rd),
		.de_is_load (de_is_load),
		.stall      (stall)
	);

	alu_decoder alu_dec_i (
		.clk      (clk),
		.nrst     (nrst),
		.instr_in (instr_in),
		.stall    (stall),
		.alu_op   (alu_op)
	);

	cw_pipeline pipe_i (
		.clk        (clk),
		.nrst       (nrst),
		.rom_cw     (rom_cw),
		.instr_rd   (instr_in.r.rd),
		.stall      (stall),
		.cw_out     (cw_out),
		.de_rd      (de_rd),
		.de_is_load (de_is_load)
	);

endmodule

`default_nettype wire

// ==== verif/cu_ref_model.svh ====
// cu_ref_model: expected control words, ALU codes, hazard rule and stage shifting for cu_tb
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

// control word built flag by flag from the opcode
function automatic ctrl_word_t ref_cw(input logic [6:0] op);
	ctrl_word_t w;
	if (!(op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store,
			op_imm, op_reg, op_fence, op_system}))
		return cw_fetch_only;
	w = '0;
	w.fe = 2'b11;
	w.de.rs1_en = op inside {op_jalr, op_branch, op_load, op_store, op_imm, op_reg,
		op_fence, op_system};
	w.de.rs2_en = op inside {op_branch, op_store, op_reg, op_fence, op_system};
	w.de.imm_en = op inside {op_auipc, op_lui, op_branch, op_jal, op_jalr, op_load,
		op_store, op_imm};
	w.de.de_en = 1'b1;
	w.ex.sel_a_pc = !(op inside {op_auipc, op_jalr});
	w.ex.sel_b_imm = op inside {op_auipc, op_lui, op_branch, op_jalr, op_load, op_store,
		op_imm};
	w.ex.em_en = 1'b1;
	w.mem.dram_we = (op == op_store);
	w.mem.dram_re = (op == op_load);
	w.mem.mw_en = 1'b1;
	w.wb.sel_c = (op != op_load);
	w.wb.sel_d = op inside {op_jal, op_jalr};
	w.wb.rf_we = !(op inside {op_branch, op_store});
	return w;
endfunction

function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
	case (f3)
		3'd0:    return alt ? alu_sub : alu_add;
		3'd1:    return alu_sll;
		3'd2:    return alu_slt;
		3'd3:    return alu_sltu;
		3'd4:    return alu_xor;
		3'd5:    return alt ? alu_sra : alu_srl;
		3'd6:    return alu_or;
		default: return alu_and;
	endcase
endfunction

function automatic alu_op_t ref_alu(input logic [31:0] ins);
	case (ins[6:0])
		op_load, op_store: return alu_addr;
		op_auipc:          return alu_add;
		op_reg:            return ins[25] ? alu_copy_b : arith_op(ins[14:12], ins[30]);
		op_imm:            return arith_op(ins[14:12], (ins[14:12] == 3'd5) && ins[30]);
		default:           return alu_copy_b; // lui too
	endcase
endfunction

// load feeds anything, anything feeds a branch
function automatic logic ref_stall(input logic [31:0] ins, input logic [4:0] p_rd,
		input logic p_load);
	logic [6:0] op;
	logic [4:0] s1;
	logic [4:0] s2;
	op = ins[6:0];
	s1 = (op inside {op_lui, op_auipc, op_jal}) ? 5'd0 : ins[19:15];
	s2 = (op inside {op_reg, op_branch, op_store}) ? ins[24:20] : 5'd0;
	return (p_rd != 5'd0) && ((p_rd == s1) || (p_rd == s2)) && (p_load || op == op_branch);
endfunction

// one clock edge of the expected pipeline
function automatic void shift_expected(input logic [31:0] ins, input logic stalled);
	ctrl_word_t w;
	w = stalled ? cw_bubble : ref_cw(ins[6:0]);
	exp_st[4] = exp_st[3];
	exp_st[3] = exp_st[2];
	exp_st[2] = exp_st[1];
	exp_st[1] = w;
	exp_alu = stalled ? alu_copy_b : ref_alu(ins);
	prev_rd = w.wb.rf_we ? ins[11:7] : 5'd0;
	prev_load = w.mem.dram_re;
endfunction

`endif

// ==== verif/cu_tb.sv ====
// control unit testbench with directed and random tests against a reference model
`timescale 1ns/10ps
`default_nettype none

module cu_tb;
	import cu_pkg::*;

	localparam int rand_len   = 200;
	localparam int max_cycles = 4 * rand_len + 600; // stalls double a slot at most
	localparam logic [31:0] nop = 32'h0000_0013; // addi x0, x0, 0

	logic       clk = 1'b0;
	logic       nrst;
	instr_u     instr_in;
	ctrl_word_t cw_out;
	alu_op_t    alu_op;

	ctrl_word_t  exp_st [1:4]; // expected stage contents
	alu_op_t     exp_alu;
	logic [4:0]  prev_rd;
	logic        prev_load;
	logic [15:0] lfsr = 16'd23277;
	int          mismatches = 0;
	int          failures = 0;

	`include "cu_ref_model.svh"

	cu_top dut_i (
		.clk      (clk),
		.nrst     (nrst),
		.instr_in (instr_in),
		.cw_out   (cw_out),
		.alu_op   (alu_op)
	);

	always #5 clk = ~clk;

	// taps x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	task automatic check_outputs(input logic [31:0] ins, input logic stalled);
		ctrl_word_t exp;
		exp = ref_cw(ins[6:0]);
		if (stalled)
			exp.fe = '0;
		exp.de = exp_st[1].de;
		exp.ex = exp_st[2].ex;
		exp.mem = exp_st[3].mem;
		exp.wb = exp_st[4].wb;
		assert (cw_out == exp) else begin
			mismatches++;
			$display("Mismatch cw_out: got %h expected %h (instr %h)", cw_out, exp, ins);
		end
		assert (alu_op == exp_alu) else begin
			mismatches++;
			$display("Mismatch alu_op: got %h expected %h", alu_op, exp_alu);
		end
	endtask

	task automatic present(input logic [31:0] ins, output logic stalled, output logic frozen);
		@(posedge clk);
		instr_in <= ins;
		@(negedge clk);
		frozen = !cw_out.fe.pc_en;
		stalled = ref_stall(ins, prev_rd, prev_load);
		check_outputs(ins, stalled);
		shift_expected(ins, stalled);
	endtask

	// re-present while a stall is predicted, bubbles are the cycles the DUT froze fetch
	task automatic issue(input logic [31:0] ins, output int bubbles);
		logic stalled;
		logic frozen;
		bubbles = 0;
		present(ins, stalled, frozen);
		if (frozen)
			bubbles++;
		while (stalled) begin
			present(ins, stalled, frozen);
			if (frozen)
				bubbles++;
		end
	endtask

	task automatic drain(input int n);
		int b;
		repeat (n) issue(nop, b);
	endtask

	task automatic apply_reset();
		ctrl_word_t exp;
		nrst <= 1'b0;
		instr_in <= '0; // unknown opcode as from an empty icache
		for (int k = 1; k <= 4; k++)
			exp_st[k] = '0;
		exp_alu = alu_copy_b;
		prev_rd = '0;
		prev_load = 1'b0;
		repeat (10) begin
			@(negedge clk);
			assert (cw_out == '0 && alu_op == alu_copy_b) else begin
				mismatches++;
				$display("Mismatch cw_out/alu_op in reset: got %h / %h", cw_out, alu_op);
			end
		end
		@(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		exp = '0;
		exp.fe.pc_en = 1'b1;
		assert (cw_out == exp) else begin
			mismatches++;
			$display("Mismatch cw_out after reset: got %h expected %h", cw_out, exp);
		end
		shift_expected(32'h0, 1'b0);
	endtask

	task automatic walk_opcodes();
		logic [31:0] progs [11];
		int b;
		progs = '{32'h0000_10b7, 32'h0000_0117, 32'h0000_01ef, 32'h0000_8267,
			enc_r(0, 7, 6, 0, 0, op_branch), 32'h0004_2283, enc_r(0, 9, 8, 2, 4, op_store),
			32'h0050_8313, enc_r(0, 2, 1, 0, 3, op_reg), 32'h0000_000f, 32'h0000_0073};
		foreach (progs[k]) begin
			issue(progs[k], b);
			drain(4);
		end
	endtask

	task automatic sweep_alu_codes();
		int b;
		for (int f = 0; f < 8; f++) begin
			issue(enc_r(0, 2, 1, f[2:0], 3, op_reg), b);
			issue({12'h0a5, 5'd1, f[2:0], 5'd4, op_imm}, b);
		end
		issue(enc_r(7'h20, 2, 1, 3'd0, 3, op_reg), b); // sub
		issue(enc_r(7'h20, 2, 1, 3'd5, 3, op_reg), b); // sra
		issue({12'h403, 5'd1, 3'd5, 5'd4, op_imm}, b); // srai
		issue(enc_r(7'h01, 2, 1, 3'd0, 3, op_reg), b); // mul
		drain(4);
	endtask

	task automatic hazard_pair(input logic [31:0] prod, input logic [31:0] cons,
			input int exp_bubbles);
		int b;
		issue(prod, b);
		issue(cons, b);
		assert (b == exp_bubbles) else begin
			failures++;
			$display("Wrong stall count: %h then %h gave %0d bubbles, %0d expected",
				prod, cons, b, exp_bubbles);
		end
		drain(4);
	endtask

	task automatic run_random_stream();
		logic [31:0] ins;
		logic [31:0] sel;
		logic [31:0] f7;
		int b;
		repeat (rand_len) begin
			ins = rand_bits(32);
			sel = rand_bits(4) % 12;
			f7 = rand_bits(2);
			ins[19:15] = ins[19:15] & 5'h07; // small register set for more hazards
			ins[24:20] = ins[24:20] & 5'h07;
			ins[11:7] = ins[11:7] & 5'h07;
			ins[31:25] = (f7 == 1) ? 7'h20 : ((f7 == 2) ? 7'h01 : 7'h00);
			case (sel)
				0: ins[6:0] = op_lui;
				1: ins[6:0] = op_auipc;
				2: ins[6:0] = op_jal;
				3: ins[6:0] = op_jalr;
				4: ins[6:0] = op_branch;
				5: ins[6:0] = op_load;
				6: ins[6:0] = op_store;
				7: ins[6:0] = op_imm;
				8: ins[6:0] = op_reg;
				9: ins[6:0] = op_fence;
				10: ins[6:0] = op_system;
				default: ins[6:0] = 7'h00;
			endcase
			issue(ins, b);
		end
		drain(4);
	endtask

	initial begin
		#(max_cycles * 10);
		$display("Timeout: run did not finish within %0d cycles", max_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		apply_reset();
		drain(4);
		walk_opcodes();
		sweep_alu_codes();
		hazard_pair(32'h0004_2283, enc_r(0, 9, 5, 0, 6, op_reg), 1); // lw x5 then add
		hazard_pair(32'h0004_2283, enc_r(0, 9, 5, 0, 0, op_branch), 1);
		hazard_pair(enc_r(0, 2, 1, 0, 5, op_reg), enc_r(0, 9, 5, 0, 0, op_branch), 1);
		hazard_pair(enc_r(0, 2, 1, 0, 5, op_reg), enc_r(0, 9, 5, 0, 6, op_reg), 0);
		hazard_pair(enc_r(0, 2, 1, 0, 0, op_reg), enc_r(0, 0, 0, 0, 0, op_branch), 0);
		hazard_pair(32'h0004_2283, {12'h005, 5'd7, 3'd0, 5'd6, op_imm}, 0);
		run_random_stream();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
rtl/cu_pkg.sv
rtl/cw_rom.sv
rtl/hazard_ctrl.sv
rtl/alu_decoder.sv
rtl/cw_pipeline.sv
rtl/cu_top.sv
verif/cu_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --timing --assert
TOP      = cu_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
